/* all.f */
+incdir+source
source/scc_pkg.sv
source/scc_wave_ram.sv
source/scc_reg_decode.sv
source/scc_voice.sv
source/scc_mixer.sv
source/scc_top.sv
dv/scc_tb.sv

/* dv/scc_tb.sv */
`timescale 1ns/1ns

module scc_tb
    import scc_pkg::*;
();

    localparam int         NUM_VOICES     = 3;
    localparam int         WAVE_DEPTH     = 32;
    localparam int         CLK_HALF       = 2;
    localparam int         RESET_CYCLES   = 8;
    localparam int         TIMEOUT_CYCLES = 20000;
    localparam logic [7:0] FREQ_BASE      = 8'h80;
    localparam logic [7:0] VOL_BASE       = 8'h8A;
    localparam logic [7:0] ENABLE_ADDR    = 8'h8F;
    localparam logic [31:0] SEED          = 32'h3ff1_a832;

    logic       emuclk = 1'b0;
    logic       rst_n;
    cpu_req_t   req;
    logic [7:0] db;
    mix_t       sound;

    int cycle_count = 0;
    int err_count;
    int check_count;
    int tests_run;
    int tests_failed;

    // reference copy of every wave byte written
    logic [7:0] wave_bytes [NUM_VOICES][WAVE_DEPTH];

    always #CLK_HALF emuclk = ~emuclk;

    scc_top i_scc_top (
        .i_emuclk (emuclk),
        .i_rst_n  (rst_n),
        .i_req    (req),
        .o_db     (db),
        .o_sound  (sound)
    );

    // watchdog
    always @(posedge emuclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, a test never finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // signed byte times volume, arithmetic shift by 4
    function automatic int scaled(input logic [7:0] sample, input int vol);
        int p;
        p = int'($signed(sample)) * vol;
        return p >>> 4;
    endfunction

    // ramp entry k holds 4k, played at volume 15
    function automatic int ramp_step(input mix_t value);
        int found;
        found = -1;
        for (int k = 0; k < WAVE_DEPTH; k++) begin
            if (scaled(8'(4 * k), 15) == int'(value)) begin
                found = k;
            end
        end
        return found;
    endfunction

    task automatic wait_cycle();
        @(posedge emuclk);
        #1;
    endtask

    task automatic cpu_write(input logic [7:0] wr_addr, input logic [7:0] wr_data);
        int v_idx;
        int a_idx;
        v_idx = int'(wr_addr) / WAVE_DEPTH;
        a_idx = int'(wr_addr) % WAVE_DEPTH;
        wait_cycle();
        req = '{wr: 1'b1, rd: 1'b0, addr: wr_addr, wdata: wr_data};
        if (v_idx < NUM_VOICES) begin
            wave_bytes[v_idx][a_idx] = wr_data;
        end
        wait_cycle();
        req = '0;
    endtask

    // data is sampled in the cycle after the request
    task automatic cpu_read(input logic [7:0] rd_addr, output logic [7:0] rd_data);
        wait_cycle();
        req = '{wr: 1'b0, rd: 1'b1, addr: rd_addr, wdata: 8'h00};
        wait_cycle();
        req = '0;
        rd_data = db;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic finish_test(input string test_name, input int errs_at_start);
        int errs;
        errs = err_count - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    task automatic wait_sound_change(output int at_cycle);
        mix_t prev;
        prev = sound;
        wait_cycle();
        while (sound === prev) begin
            wait_cycle();
        end
        at_cycle = cycle_count;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int errs_at_start;
        errs_at_start = err_count;
        for (int i = 0; i < 10; i++) begin
            wait_cycle();
            check_value("reset_state", "o_sound", 0, 32'(sound));
            check_value("reset_state", "o_db", 0, 32'(db));
        end
        finish_test("reset_state", errs_at_start);
    endtask

    task automatic test_wave_readback();
        int          errs_at_start;
        logic [31:0] rng;
        logic [7:0]  rd_data;
        errs_at_start = err_count;
        rng = SEED;
        for (int v = 0; v < NUM_VOICES; v++) begin
            for (int a = 0; a < WAVE_DEPTH; a++) begin
                rng = xorshift32(rng);
                cpu_write(8'(v * WAVE_DEPTH + a), rng[7:0]);
            end
        end
        for (int v = 0; v < NUM_VOICES; v++) begin
            for (int a = 0; a < WAVE_DEPTH; a++) begin
                cpu_read(8'(v * WAVE_DEPTH + a), rd_data);
                check_value("wave_readback", "read data", 32'(wave_bytes[v][a]), 32'(rd_data));
                wait_cycle();
                check_value("wave_readback", "idle o_db", 0, 32'(db));
            end
        end
        // register addresses read as zero even while holding data
        cpu_write(FREQ_BASE, 8'h5a);
        cpu_read(FREQ_BASE, rd_data);
        check_value("wave_readback", "register read", 0, 32'(rd_data));
        cpu_write(ENABLE_ADDR, 8'h05);
        cpu_read(ENABLE_ADDR, rd_data);
        check_value("wave_readback", "register read", 0, 32'(rd_data));
        finish_test("wave_readback", errs_at_start);
    endtask

    task automatic test_scaling_enable();
        int         errs_at_start;
        int         expected;
        int         vols [NUM_VOICES];
        logic [7:0] levels [NUM_VOICES];
        errs_at_start = err_count;
        // 100, -128 and -45
        levels = '{8'd100, 8'h80, 8'hd3};
        for (int v = 0; v < NUM_VOICES; v++) begin
            for (int a = 0; a < WAVE_DEPTH; a++) begin
                cpu_write(8'(v * WAVE_DEPTH + a), levels[v]);
            end
        end
        for (int set = 0; set < 2; set++) begin
            if (set == 0) begin
                vols = '{15, 9, 4};
            end else begin
                vols = '{7, 15, 1};
            end
            for (int v = 0; v < NUM_VOICES; v++) begin
                cpu_write(VOL_BASE + 8'(v), 8'(vols[v]));
            end
            for (int mask = 0; mask < 8; mask++) begin
                cpu_write(ENABLE_ADDR, 8'(mask));
                wait_cycle();
                wait_cycle();
                expected = 0;
                for (int v = 0; v < NUM_VOICES; v++) begin
                    if (((mask >> v) & 1) == 1) begin
                        expected += scaled(levels[v], vols[v]);
                    end
                end
                check_value("scaling_enable", "o_sound", expected, 32'(sound));
            end
        end
        finish_test("scaling_enable", errs_at_start);
    endtask

    task automatic test_stepping_period();
        int errs_at_start;
        int periods [3];
        int last_cycle;
        int now_cycle;
        int k;
        errs_at_start = err_count;
        periods = '{3, 20, 100};
        for (int a = 0; a < WAVE_DEPTH; a++) begin
            cpu_write(8'(a), 8'(4 * a));
        end
        cpu_write(VOL_BASE, 8'd15);
        cpu_write(ENABLE_ADDR, 8'h01);
        for (int p = 0; p < 3; p++) begin
            cpu_write(FREQ_BASE, 8'(periods[p]));
            cpu_write(FREQ_BASE + 8'd1, 8'(periods[p] >> 8));
            // two changes let the old period run out
            wait_sound_change(now_cycle);
            wait_sound_change(last_cycle);
            k = ramp_step(sound);
            if (k < 0) begin
                err_count++;
                $display("test stepping_period: o_sound value %0d is not on the ramp", sound);
                k = 0;
            end
            for (int step = 0; step < WAVE_DEPTH; step++) begin
                wait_sound_change(now_cycle);
                check_value("stepping_period", "step length", periods[p] + 1,
                            now_cycle - last_cycle);
                k = (k + 1) % WAVE_DEPTH;
                check_value("stepping_period", "ramp value", scaled(8'(4 * k), 15), 32'(sound));
                last_cycle = now_cycle;
            end
        end
        finish_test("stepping_period", errs_at_start);
    endtask

    task automatic test_write_during_playback();
        int         errs_at_start;
        int         target;
        int         waited;
        logic       seen;
        logic [7:0] entry_addr;
        logic [7:0] new_byte;
        logic [7:0] rd_data;
        errs_at_start = err_count;
        entry_addr = 8'd5;
        // -100
        new_byte = 8'h9c;
        cpu_write(FREQ_BASE, 8'd10);
        cpu_write(entry_addr, new_byte);
        cpu_read(entry_addr, rd_data);
        check_value("write_during_playback", "read back", 32'(new_byte), 32'(rd_data));
        target = scaled(new_byte, 15);
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < 2 * WAVE_DEPTH * 11) begin
            wait_cycle();
            waited++;
            if (int'(sound) == target) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            err_count++;
            $display("test write_during_playback: new byte of entry %0d never reached o_sound",
                     entry_addr);
        end
        finish_test("write_during_playback", errs_at_start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        req          = '0;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge emuclk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_wave_readback();
        test_scaling_enable();
        test_stepping_period();
        test_write_during_playback();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the scc testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module scc_tb \
    -Mdir "$OBJ_DIR" -o scc_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/scc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

/* source/scc_defs.svh */
`ifndef SCC_DEFS_SVH
`define SCC_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// voice and wave memory geometry
//////////////////////////////////////////////////////////////////////

// number of independent voices
`define SCC_NUM_VOICES      3

// bytes per voice wave memory
`define SCC_WAVE_DEPTH      32
`define SCC_WAVE_AW         5

//////////////////////////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////////////////////////

// each voice owns one 32-byte window, voice n at n*32
`define SCC_ADDR_WAVE_SPAN  32

// low frequency byte at base+2n, high nibble at base+2n+1
`define SCC_ADDR_FREQ_BASE  8'h80

// volume nibble of voice n at base+n
`define SCC_ADDR_VOL_BASE   8'h8A

// bit n enables voice n
`define SCC_ADDR_ENABLE     8'h8F

`endif

/* source/scc_mixer.sv */
`timescale 1ns/1ns

`include "scc_defs.svh"

module scc_mixer
    import scc_pkg::*;
(
    input  logic       i_emuclk,
    input  logic       i_rst_n,

    input  sample_t    i_samples [`SCC_NUM_VOICES],
    input  voice_cfg_t i_cfg [`SCC_NUM_VOICES],

    output mix_t       o_sound
);

    mix_t               scaled [`SCC_NUM_VOICES];
    logic signed [12:0] sum_wide;

    //////////////////////////////////////////////////////////////////////
    // per-voice scaling
    //////////////////////////////////////////////////////////////////////

    for (genvar v = 0; v < `SCC_NUM_VOICES; v++) begin : g_scale
        logic signed [11:0] product;

        // volume is unsigned, extended with a zero sign bit
        assign product = 12'(i_samples[v]) * $signed({8'b0, i_cfg[v].vol});

        // disabled voice contributes nothing
        assign scaled[v] = i_cfg[v].enable ? mix_t'(product >>> 4) : '0;

        // an enabled voice must not play unwritten wave bytes
        a_sample_known: assert property (
            @(posedge i_emuclk) disable iff (!i_rst_n)
            i_cfg[v].enable |-> !$isunknown(i_samples[v])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // sum and output register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_wide = '0;
        for (int v = 0; v < `SCC_NUM_VOICES; v++) begin
            sum_wide = sum_wide + 13'(scaled[v]);
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_sound <= '0;
        end else begin
            o_sound <= mix_t'(sum_wide);
        end
    end

endmodule

/* source/scc_pkg.sv */
`include "scc_defs.svh"

package scc_pkg;

    // wave memory address
    typedef logic [`SCC_WAVE_AW-1:0] wave_addr_t;

    // one signed wave byte
    typedef logic signed [7:0] sample_t;

    // period value, the address steps every freq+1 clocks
    typedef logic [11:0] freq_t;

    typedef logic [3:0] vol_t;

    // summed mixer output
    typedef logic signed [10:0] mix_t;

    // one-cycle cpu request, wr and rd are exclusive
    typedef struct packed {
        logic       wr;
        logic       rd;
        logic [7:0] addr;
        logic [7:0] wdata;
    } cpu_req_t;

    // per-voice settings from the register block
    typedef struct packed {
        freq_t freq;
        vol_t  vol;
        logic  enable;
        // single-cycle pulse after a frequency write
        logic  freq_load;
    } voice_cfg_t;

endpackage

/* source/scc_reg_decode.sv */
`timescale 1ns/1ns

`include "scc_defs.svh"

module scc_reg_decode
    import scc_pkg::*;
(
    input  logic                         i_emuclk,
    input  logic                         i_rst_n,

    input  cpu_req_t                     i_req,

    // per-voice settings
    output voice_cfg_t                   o_cfg [`SCC_NUM_VOICES],

    // shared wave port, one write enable per voice
    output logic [`SCC_NUM_VOICES-1:0]   o_wave_we,
    output wave_addr_t                   o_wave_addr,
    output sample_t                      o_wave_wdata,
    input  sample_t                      i_wave_rdata [`SCC_NUM_VOICES],

    output logic [7:0]                   o_db
);

    // upper address bits pick the voice window
    localparam int WIN_W = 8 - `SCC_WAVE_AW;
    localparam int SEL_W = $clog2(`SCC_NUM_VOICES);

    typedef logic [WIN_W-1:0] win_t;

    win_t                       wave_sel;
    logic                       in_wave;
    logic                       enable_wr;

    freq_t                      freq_q [`SCC_NUM_VOICES];
    vol_t                       vol_q [`SCC_NUM_VOICES];
    logic [`SCC_NUM_VOICES-1:0] freq_load_q;
    logic [`SCC_NUM_VOICES-1:0] enable_q;

    logic                       rd_valid_q;
    logic [SEL_W-1:0]           rd_voice_q;

    //////////////////////////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////////////////////////

    assign wave_sel  = i_req.addr[7:`SCC_WAVE_AW];
    assign in_wave   = wave_sel < win_t'(`SCC_NUM_VOICES);
    assign enable_wr = i_req.wr && (i_req.addr == `SCC_ADDR_ENABLE);

    // wave bytes go straight to the memories, stored at the closing edge
    assign o_wave_addr  = i_req.addr[`SCC_WAVE_AW-1:0];
    assign o_wave_wdata = i_req.wdata;

    //////////////////////////////////////////////////////////////////////
    // per-voice registers
    //////////////////////////////////////////////////////////////////////

    for (genvar v = 0; v < `SCC_NUM_VOICES; v++) begin : g_voice
        localparam logic [7:0] FREQ_LO_ADDR = 8'(`SCC_ADDR_FREQ_BASE + 2 * v);
        localparam logic [7:0] FREQ_HI_ADDR = 8'(`SCC_ADDR_FREQ_BASE + 2 * v + 1);
        localparam logic [7:0] VOL_ADDR     = 8'(`SCC_ADDR_VOL_BASE + v);

        logic freq_lo_wr;
        logic freq_hi_wr;
        logic vol_wr;

        assign freq_lo_wr = i_req.wr && (i_req.addr == FREQ_LO_ADDR);
        assign freq_hi_wr = i_req.wr && (i_req.addr == FREQ_HI_ADDR);
        assign vol_wr     = i_req.wr && (i_req.addr == VOL_ADDR);

        always_ff @(posedge i_emuclk) begin
            if (!i_rst_n) begin
                freq_q[v]      <= '0;
                vol_q[v]       <= '0;
                freq_load_q[v] <= 1'b0;
            end else begin
                if (freq_lo_wr) begin
                    freq_q[v][7:0] <= i_req.wdata;
                end
                if (freq_hi_wr) begin
                    freq_q[v][11:8] <= i_req.wdata[3:0];
                end
                if (vol_wr) begin
                    vol_q[v] <= i_req.wdata[3:0];
                end
                // either byte restarts the period counter
                freq_load_q[v] <= freq_lo_wr || freq_hi_wr;
            end
        end

        assign o_wave_we[v] = i_req.wr && in_wave && (wave_sel == win_t'(v));

        assign o_cfg[v] = '{
            freq:      freq_q[v],
            vol:       vol_q[v],
            enable:    enable_q[v],
            freq_load: freq_load_q[v]
        };
    end

    // shared enable register
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            enable_q <= '0;
        end else if (enable_wr) begin
            enable_q <= i_req.wdata[`SCC_NUM_VOICES-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read return
    //////////////////////////////////////////////////////////////////////

    // remember the voice, its memory answers one cycle later
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            rd_valid_q <= 1'b0;
            rd_voice_q <= '0;
        end else begin
            rd_valid_q <= i_req.rd && in_wave;
            rd_voice_q <= wave_sel[SEL_W-1:0];
        end
    end

    // register reads and idle cycles return zero
    assign o_db = rd_valid_q ? i_wave_rdata[rd_voice_q] : 8'h00;

    a_rd_wr_excl: assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        !(i_req.wr && i_req.rd)
    );

endmodule

/* source/scc_top.sv */
`timescale 1ns/1ns

`include "scc_defs.svh"

module scc_top
    import scc_pkg::*;
(
    input  logic       i_emuclk,
    input  logic       i_rst_n,

    input  cpu_req_t   i_req,
    output logic [7:0] o_db,

    output mix_t       o_sound
);

    voice_cfg_t                 cfg [`SCC_NUM_VOICES];
    logic [`SCC_NUM_VOICES-1:0] wave_we;
    wave_addr_t                 wave_addr;
    sample_t                    wave_wdata;
    sample_t                    wave_rdata [`SCC_NUM_VOICES];
    sample_t                    samples [`SCC_NUM_VOICES];

    scc_reg_decode i_scc_reg_decode (
        .i_emuclk     (i_emuclk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .o_cfg        (cfg),
        .o_wave_we    (wave_we),
        .o_wave_addr  (wave_addr),
        .o_wave_wdata (wave_wdata),
        .i_wave_rdata (wave_rdata),
        .o_db         (o_db)
    );

    // one voice per window, all sharing the cpu address and data
    for (genvar g = 0; g < `SCC_NUM_VOICES; g++) begin : g_voice
        scc_voice i_scc_voice (
            .i_emuclk    (i_emuclk),
            .i_rst_n     (i_rst_n),
            .i_cfg       (cfg[g]),
            .i_cpu_we    (wave_we[g]),
            .i_cpu_addr  (wave_addr),
            .i_cpu_wdata (wave_wdata),
            .o_cpu_rdata (wave_rdata[g]),
            .o_sample    (samples[g])
        );
    end

    scc_mixer i_scc_mixer (
        .i_emuclk  (i_emuclk),
        .i_rst_n   (i_rst_n),
        .i_samples (samples),
        .i_cfg     (cfg),
        .o_sound   (o_sound)
    );

endmodule

/* source/scc_voice.sv */
`timescale 1ns/1ns

`include "scc_defs.svh"

module scc_voice
    import scc_pkg::*;
(
    input  logic       i_emuclk,
    input  logic       i_rst_n,

    input  voice_cfg_t i_cfg,

    // cpu access to this voice's wave memory
    input  logic       i_cpu_we,
    input  wave_addr_t i_cpu_addr,
    input  sample_t    i_cpu_wdata,
    output sample_t    o_cpu_rdata,

    // current wave byte, one cycle behind the address
    output sample_t    o_sample
);

    freq_t      period_cnt;
    wave_addr_t wave_addr;
    logic       cnt_zero;

    //////////////////////////////////////////////////////////////////////
    // period and address counters
    //////////////////////////////////////////////////////////////////////

    assign cnt_zero = (period_cnt == '0);

    // counts freq down to zero, so one address step per freq+1 clocks
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            period_cnt <= '0;
            wave_addr  <= '0;
        end else begin
            if (i_cfg.freq_load || cnt_zero) begin
                period_cnt <= i_cfg.freq;
            end else begin
                period_cnt <= period_cnt - 1'b1;
            end

            // wraps at the end of the wave on its own
            if (cnt_zero) begin
                wave_addr <= wave_addr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // wave memory
    //////////////////////////////////////////////////////////////////////

    scc_wave_ram i_scc_wave_ram (
        .i_emuclk    (i_emuclk),
        .i_rst_n     (i_rst_n),
        .i_cpu_we    (i_cpu_we),
        .i_cpu_addr  (i_cpu_addr),
        .i_cpu_wdata (i_cpu_wdata),
        .o_cpu_rdata (o_cpu_rdata),
        .i_play_addr (wave_addr),
        .o_play_data (o_sample)
    );

    // every frequency change comes with a load pulse
    a_cnt_within_freq: assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        !i_cfg.freq_load |-> (period_cnt <= i_cfg.freq)
    );

endmodule

/* source/scc_wave_ram.sv */
`timescale 1ns/1ns

`include "scc_defs.svh"

module scc_wave_ram
    import scc_pkg::*;
(
    input  logic       i_emuclk,
    input  logic       i_rst_n,

    // cpu side
    input  logic       i_cpu_we,
    input  wave_addr_t i_cpu_addr,
    input  sample_t    i_cpu_wdata,
    output sample_t    o_cpu_rdata,

    // playback side
    input  wave_addr_t i_play_addr,
    output sample_t    o_play_data
);

    sample_t mem [`SCC_WAVE_DEPTH];

    // both reads return the array as it was before this edge's write
    always_ff @(posedge i_emuclk) begin
        if (i_cpu_we) begin
            mem[i_cpu_addr] <= i_cpu_wdata;
        end
        o_cpu_rdata <= mem[i_cpu_addr];
        o_play_data <= mem[i_play_addr];
    end

    // a write with an unknown address would corrupt any entry
    a_we_addr_known: assert property (
        @(posedge i_emuclk) disable iff (!i_rst_n)
        i_cpu_we |-> !$isunknown(i_cpu_addr)
    );

endmodule
